/* bench/tb_csr.sv */
module tb_csr;

    localparam int CLK_PERIOD = 8;

    localparam logic [3:0] OP_WRITE   = 4'd0;
    localparam logic [3:0] OP_CHECK   = 4'd1;
    localparam logic [3:0] OP_EXC     = 4'd2;
    localparam logic [3:0] OP_ERTN    = 4'd3;
    localparam logic [3:0] OP_HWINT   = 4'd4;
    localparam logic [3:0] OP_IRQ     = 4'd5;
    localparam logic [3:0] OP_TVAL    = 4'd6;
    localparam logic [3:0] OP_POLL_TI = 4'd7;

    localparam logic [5:0]  EXC_ECODE = 6'h0b;
    localparam logic [8:0]  EXC_ESUB  = 9'h1a5;
    localparam logic [31:0] EXC_ERA   = 32'h1c00_1234;

    typedef struct packed {
        logic [3:0]         op;
        logic [3:0]         test;
        csr_pkg::csr_addr_t addr;
        logic [31:0]        data;
        logic [31:0]        mask;
        logic [31:0]        exp;
    } entry_t;

    logic               clk;
    logic               aresetn;
    csr_pkg::csr_addr_t addr;
    logic               wen;
    csr_pkg::csr_data_t wdata;
    logic               exception;
    logic               ertn;
    csr_pkg::ecode_t    ecode_in;
    csr_pkg::esubcode_t esubcode_in;
    csr_pkg::csr_data_t era_in;
    csr_pkg::hw_int_t   hw_int;
    csr_pkg::csr_data_t rdata;
    csr_pkg::csr_data_t crmd;
    csr_pkg::csr_data_t era_out;
    csr_pkg::csr_data_t eentry;
    logic               cpu_interrupt;

    entry_t     tbl[$];
    logic [3:0] cur_test;
    bit         table_ready;
    integer     seed;
    int         checks;
    int         errors;
    int         test_errors;
    string      test_name[1:6];

    csr_top UUT (
        .clk           (clk),
        .aresetn       (aresetn),
        .addr          (addr),
        .wen           (wen),
        .wdata         (wdata),
        .exception     (exception),
        .ertn          (ertn),
        .ecode_in      (ecode_in),
        .esubcode_in   (esubcode_in),
        .era_in        (era_in),
        .hw_int        (hw_int),
        .rdata         (rdata),
        .crmd          (crmd),
        .era_out       (era_out),
        .eentry        (eentry),
        .cpu_interrupt (cpu_interrupt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_entry(input logic [3:0] op, input csr_pkg::csr_addr_t a,
                             input logic [31:0] data, input logic [31:0] mask,
                             input logic [31:0] exp);
        entry_t e;
        e.op   = op;
        e.test = cur_test;
        e.addr = a;
        e.data = data;
        e.mask = mask;
        e.exp  = exp;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0]        r;
        csr_pkg::csr_addr_t a;
        int                 k;
        seed = 32'hb96f6b34;
        cur_test = 4'd1;
        add_entry(OP_CHECK, csr_pkg::ADDR_CRMD, 32'h0, 32'hffff_ffff, 32'h0000_0008);
        add_entry(OP_CHECK, csr_pkg::ADDR_ESTAT, 32'h0, 32'hffff_ffff, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_ERA, 32'h0, 32'hffff_ffff, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_TCFG, 32'h0, 32'hffff_ffff, 32'h0);
        add_entry(OP_IRQ, csr_pkg::ADDR_CRMD, 32'h0, 32'h1, 32'h0);
        cur_test = 4'd2;
        for (k = 0; k < 5; k++) begin
            r = $random(seed);
            a = (k == 4) ? csr_pkg::ADDR_TID : csr_pkg::ADDR_SAVE0 + k[13:0];
            add_entry(OP_WRITE, a, r, 32'h0, 32'h0);
            add_entry(OP_CHECK, a, 32'h0, 32'hffff_ffff, r);
        end
        // Low six bits of EENTRY are hardwired to zero
        add_entry(OP_WRITE, csr_pkg::ADDR_EENTRY, 32'hdead_beff, 32'h0, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_EENTRY, 32'h0, 32'hffff_ffff, 32'hdead_bec0);
        add_entry(OP_WRITE, csr_pkg::ADDR_ECFG, 32'hffff_ffff, 32'h0, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_ECFG, 32'h0, 32'hffff_ffff, 32'h0000_1fff);
        add_entry(OP_WRITE, csr_pkg::ADDR_ECFG, 32'h0, 32'h0, 32'h0);
        cur_test = 4'd3;
        // PG=1 with DA=1 is illegal, the pair keeps its old value
        add_entry(OP_WRITE, csr_pkg::ADDR_CRMD, 32'h0000_001e, 32'h0, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_CRMD, 32'h0, 32'hffff_ffff, 32'h0000_000e);
        add_entry(OP_WRITE, csr_pkg::ADDR_CRMD, 32'h0000_0010, 32'h0, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_CRMD, 32'h0, 32'hffff_ffff, 32'h0000_0010);
        add_entry(OP_WRITE, csr_pkg::ADDR_CRMD, 32'h0000_0008, 32'h0, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_CRMD, 32'h0, 32'hffff_ffff, 32'h0000_0008);
        cur_test = 4'd4;
        add_entry(OP_WRITE, csr_pkg::ADDR_CRMD, 32'h0000_000f, 32'h0, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_CRMD, 32'h0, 32'hffff_ffff, 32'h0000_000f);
        add_entry(OP_EXC, csr_pkg::ADDR_CRMD, EXC_ERA, 32'h0, {17'd0, EXC_ESUB, EXC_ECODE});
        add_entry(OP_CHECK, csr_pkg::ADDR_PRMD, 32'h0, 32'hffff_ffff, 32'h0000_0007);
        add_entry(OP_CHECK, csr_pkg::ADDR_CRMD, 32'h0, 32'h0000_0007, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_ERA, 32'h0, 32'hffff_ffff, EXC_ERA);
        add_entry(OP_CHECK, csr_pkg::ADDR_ESTAT, 32'h0, 32'h7fff_0000,
                  {1'b0, EXC_ESUB, EXC_ECODE, 16'h0});
        add_entry(OP_ERTN, csr_pkg::ADDR_CRMD, 32'h0, 32'h0, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_CRMD, 32'h0, 32'hffff_ffff, 32'h0000_000f);
        cur_test = 4'd5;
        add_entry(OP_WRITE, csr_pkg::ADDR_ECFG, 32'h0000_0004, 32'h0, 32'h0);
        add_entry(OP_HWINT, csr_pkg::ADDR_CRMD, 32'h0000_0001, 32'h0, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_ESTAT, 32'h0, 32'h0000_03ff, 32'h0000_0004);
        add_entry(OP_IRQ, csr_pkg::ADDR_CRMD, 32'h0, 32'h1, 32'h1);
        add_entry(OP_WRITE, csr_pkg::ADDR_ECFG, 32'h0, 32'h0, 32'h0);
        add_entry(OP_IRQ, csr_pkg::ADDR_CRMD, 32'h0, 32'h1, 32'h0);
        add_entry(OP_HWINT, csr_pkg::ADDR_CRMD, 32'h0, 32'h0, 32'h0);
        cur_test = 4'd6;
        // EN=1, one-shot, INITVAL=3
        add_entry(OP_WRITE, csr_pkg::ADDR_TCFG, 32'h0000_000d, 32'h0, 32'h0);
        add_entry(OP_TVAL, csr_pkg::ADDR_TVAL, 32'h0, 32'h0, 32'd13);
        add_entry(OP_POLL_TI, csr_pkg::ADDR_ESTAT, 32'h0, 32'h0, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_ESTAT, 32'h0, 32'h0000_0800, 32'h0000_0800);
        add_entry(OP_IRQ, csr_pkg::ADDR_CRMD, 32'h0, 32'h1, 32'h0);
        add_entry(OP_WRITE, csr_pkg::ADDR_ECFG, 32'h0000_0800, 32'h0, 32'h0);
        add_entry(OP_IRQ, csr_pkg::ADDR_CRMD, 32'h0, 32'h1, 32'h1);
        add_entry(OP_WRITE, csr_pkg::ADDR_TICLR, 32'h0000_0001, 32'h0, 32'h0);
        add_entry(OP_CHECK, csr_pkg::ADDR_ESTAT, 32'h0, 32'h0000_0800, 32'h0);
        add_entry(OP_IRQ, csr_pkg::ADDR_CRMD, 32'h0, 32'h1, 32'h0);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("error at time %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic apply_entry(input entry_t e);
        logic [31:0] v1;
        logic [31:0] v2;
        int          n;
        bit          seen;
        @(posedge clk);
        // Pulses last one cycle, the next entry clears them
        wen       <= 1'b0;
        exception <= 1'b0;
        ertn      <= 1'b0;
        addr      <= e.addr;
        case (e.op)
            OP_WRITE: begin
                wen   <= 1'b1;
                wdata <= e.data;
            end
            OP_CHECK: begin
                @(negedge clk);
                check_value("rdata", rdata & e.mask, e.exp);
                // Direct outputs carry the same registers
                case (e.addr)
                    csr_pkg::ADDR_CRMD:   check_value("crmd", crmd & e.mask, e.exp);
                    csr_pkg::ADDR_ERA:    check_value("era_out", era_out & e.mask, e.exp);
                    csr_pkg::ADDR_EENTRY: check_value("eentry", eentry & e.mask, e.exp);
                    default: ;
                endcase
            end
            OP_EXC: begin
                exception   <= 1'b1;
                era_in      <= e.data;
                ecode_in    <= e.exp[5:0];
                esubcode_in <= e.exp[14:6];
            end
            OP_ERTN: ertn <= 1'b1;
            OP_HWINT: hw_int <= e.data[7:0];
            OP_IRQ: begin
                @(negedge clk);
                check_value("cpu_interrupt", {31'd0, cpu_interrupt}, e.exp);
            end
            OP_TVAL: begin
                @(negedge clk);
                // Reload lands two edges after the TCFG write
                for (n = 0; n < 4 && rdata == 32'd0; n++) begin
                    @(negedge clk);
                end
                v1 = rdata;
                @(negedge clk);
                v2 = rdata;
                checks++;
                if (v1 > e.exp || v1 == 32'd0 || v2 !== v1 - 32'd1) begin
                    errors++;
                    test_errors++;
                    $display(
                        "error at time %0t: tval expected <= %0d and falling, actual %h then %h",
                        $time, e.exp, v1, v2);
                end
            end
            OP_POLL_TI: begin
                seen = 1'b0;
                for (n = 0; n < 40 && !seen; n++) begin
                    @(negedge clk);
                    if (rdata[csr_pkg::TI_BIT]) begin
                        seen = 1'b1;
                    end
                end
                checks++;
                if (!seen) begin
                    errors++;
                    test_errors++;
                    $display("timer interrupt bit in ESTAT did not rise within 40 cycles");
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        wait (table_ready);
        repeat (tbl.size() * 50) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", tbl.size() * 50);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        bit last;
        clk         = 1'b0;
        aresetn     = 1'b0;
        addr        = '0;
        wen         = 1'b0;
        wdata       = '0;
        exception   = 1'b0;
        ertn        = 1'b0;
        ecode_in    = '0;
        esubcode_in = '0;
        era_in      = '0;
        hw_int      = '0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        test_name[1] = "reset values";
        test_name[2] = "register read back";
        test_name[3] = "crmd pg/da rule";
        test_name[4] = "exception and ertn";
        test_name[5] = "hardware interrupt";
        test_name[6] = "timer interrupt";
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        aresetn <= 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            apply_entry(tbl[i]);
            if (i + 1 == tbl.size()) begin
                last = 1'b1;
            end else begin
                last = tbl[i + 1].test != tbl[i].test;
            end
            if (last) begin
                if (test_errors == 0) begin
                    $display("test %0d (%s): ok", tbl[i].test, test_name[tbl[i].test]);
                end else begin
                    $display("test %0d (%s): failed with %0d errors",
                             tbl[i].test, test_name[tbl[i].test], test_errors);
                end
                test_errors = 0;
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the CSR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_csr

out=$(./obj_dir/Vtb_csr)
echo "$out"

# Exit status follows the search for the pass message
echo "$out" | grep -q "ALL TESTS PASSED"

/* source/csr_pkg.sv */
package csr_pkg;

    // Basic widths
    localparam int ADDR_W    = 14;
    localparam int DATA_W    = 32;
    localparam int INT_VEC_W = 13;
    localparam int HW_INT_W  = 8;

    typedef logic [ADDR_W-1:0]    csr_addr_t;
    typedef logic [DATA_W-1:0]    csr_data_t;
    typedef logic [1:0]           plv_t;
    typedef logic [5:0]           ecode_t;
    typedef logic [8:0]           esubcode_t;
    typedef logic [HW_INT_W-1:0]  hw_int_t;
    typedef logic [INT_VEC_W-1:0] int_vec_t;

    // CSR address map
    localparam csr_addr_t ADDR_CRMD   = 14'h000;
    localparam csr_addr_t ADDR_PRMD   = 14'h001;
    localparam csr_addr_t ADDR_ECFG   = 14'h004;
    localparam csr_addr_t ADDR_ESTAT  = 14'h005;
    localparam csr_addr_t ADDR_ERA    = 14'h006;
    localparam csr_addr_t ADDR_EENTRY = 14'h00c;
    localparam csr_addr_t ADDR_SAVE0  = 14'h030;
    localparam csr_addr_t ADDR_SAVE1  = 14'h031;
    localparam csr_addr_t ADDR_SAVE2  = 14'h032;
    localparam csr_addr_t ADDR_SAVE3  = 14'h033;
    localparam csr_addr_t ADDR_TID    = 14'h040;
    localparam csr_addr_t ADDR_TCFG   = 14'h041;
    localparam csr_addr_t ADDR_TVAL   = 14'h042;
    localparam csr_addr_t ADDR_TICLR  = 14'h044;

    // CRMD fields
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_IE      = 2;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_HI = 6;
    localparam int CRMD_DATF_LO = 5;
    localparam int CRMD_DATM_HI = 8;
    localparam int CRMD_DATM_LO = 7;

    // PRMD fields
    localparam int PRMD_PPLV_HI = 1;
    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PIE     = 2;

    // ESTAT fields
    localparam int ESTAT_SOFT_HI  = 1;
    localparam int ESTAT_SOFT_LO  = 0;
    localparam int ESTAT_HARD_HI  = 9;
    localparam int ESTAT_HARD_LO  = 2;
    localparam int ESTAT_ECODE_HI = 21;
    localparam int ESTAT_ECODE_LO = 16;
    localparam int ESTAT_ESUB_HI  = 30;
    localparam int ESTAT_ESUB_LO  = 22;

    // Timer interrupt, same index in ESTAT.IS and ECFG.LIE
    localparam int TI_BIT = 11;

    // EENTRY is 64-byte aligned
    localparam int EENTRY_VA_LO = 6;

    // TCFG fields
    localparam int TCFG_EN         = 0;
    localparam int TCFG_PERIODIC   = 1;
    localparam int TCFG_INITVAL_HI = 31;
    localparam int TCFG_INITVAL_LO = 2;

endpackage

/* source/csr_read_mux.sv */
module csr_read_mux (
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::csr_data_t crmd,
    input  csr_pkg::csr_data_t prmd,
    input  csr_pkg::csr_data_t era,
    input  csr_pkg::csr_data_t eentry,
    input  csr_pkg::csr_data_t save0,
    input  csr_pkg::csr_data_t save1,
    input  csr_pkg::csr_data_t save2,
    input  csr_pkg::csr_data_t save3,
    input  csr_pkg::csr_data_t tid,
    input  csr_pkg::csr_data_t tcfg,
    input  csr_pkg::csr_data_t tval,
    input  csr_pkg::int_vec_t  ecfg_lie,
    input  logic [1:0]         estat_soft,
    input  csr_pkg::ecode_t    estat_ecode,
    input  csr_pkg::esubcode_t estat_esubcode,
    input  logic               ti,
    input  csr_pkg::hw_int_t   hw_int,
    output csr_pkg::csr_data_t rdata,
    output logic               cpu_interrupt
);

    csr_pkg::int_vec_t  is_vec;
    csr_pkg::csr_data_t estat;

    // Pending interrupt vector, hardware lines pass straight through
    always_comb begin
        is_vec = '0;
        is_vec[csr_pkg::ESTAT_SOFT_HI:csr_pkg::ESTAT_SOFT_LO] = estat_soft;
        is_vec[csr_pkg::ESTAT_HARD_HI:csr_pkg::ESTAT_HARD_LO] = hw_int;
        is_vec[csr_pkg::TI_BIT]                               = ti;
    end

    always_comb begin
        estat = '0;
        estat[csr_pkg::INT_VEC_W-1:0]                        = is_vec;
        estat[csr_pkg::ESTAT_ECODE_HI:csr_pkg::ESTAT_ECODE_LO] = estat_ecode;
        estat[csr_pkg::ESTAT_ESUB_HI:csr_pkg::ESTAT_ESUB_LO]   = estat_esubcode;
    end

    always_comb begin
        case (addr)
            csr_pkg::ADDR_CRMD:   rdata = crmd;
            csr_pkg::ADDR_PRMD:   rdata = prmd;
            csr_pkg::ADDR_ECFG:   rdata = csr_pkg::csr_data_t'(ecfg_lie);
            csr_pkg::ADDR_ESTAT:  rdata = estat;
            csr_pkg::ADDR_ERA:    rdata = era;
            csr_pkg::ADDR_EENTRY: rdata = eentry;
            csr_pkg::ADDR_SAVE0:  rdata = save0;
            csr_pkg::ADDR_SAVE1:  rdata = save1;
            csr_pkg::ADDR_SAVE2:  rdata = save2;
            csr_pkg::ADDR_SAVE3:  rdata = save3;
            csr_pkg::ADDR_TID:    rdata = tid;
            csr_pkg::ADDR_TCFG:   rdata = tcfg;
            csr_pkg::ADDR_TVAL:   rdata = tval;
            // TICLR is write-only
            default:              rdata = '0;
        endcase
    end

    // Global enable gates any locally enabled pending line
    assign cpu_interrupt = crmd[csr_pkg::CRMD_IE] && (|(is_vec & ecfg_lie));

endmodule

/* source/csr_timer.sv */
module csr_timer (
    input  logic               clk,
    input  logic               aresetn,
    input  csr_pkg::csr_addr_t addr,
    input  logic               wen,
    input  csr_pkg::csr_data_t wdata,
    output csr_pkg::csr_data_t tid,
    output csr_pkg::csr_data_t tcfg,
    output csr_pkg::csr_data_t tval,
    output logic               ti
);

    logic tcfg_en;
    logic tcfg_periodic;
    logic [csr_pkg::TCFG_INITVAL_HI:csr_pkg::TCFG_INITVAL_LO] tcfg_initval;

    logic               tcfg_we;
    logic               ticlr_we;
    logic               tcfg_wr_q;
    logic               reload;
    logic               time_out;
    csr_pkg::csr_data_t reload_val;

    assign tcfg_we  = wen && addr == csr_pkg::ADDR_TCFG;
    assign ticlr_we = wen && addr == csr_pkg::ADDR_TICLR;

    // One above INITVAL<<2 so that INITVAL of zero still fires
    assign reload_val = {tcfg_initval, 2'b01};

    assign tcfg = {tcfg_initval, tcfg_periodic, tcfg_en};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tid           <= '0;
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else begin
            if (wen && addr == csr_pkg::ADDR_TID) begin
                tid <= wdata;
            end
            if (tcfg_we) begin
                tcfg_en       <= wdata[csr_pkg::TCFG_EN];
                tcfg_periodic <= wdata[csr_pkg::TCFG_PERIODIC];
                tcfg_initval  <= wdata[csr_pkg::TCFG_INITVAL_HI:csr_pkg::TCFG_INITVAL_LO];
            end
        end
    end

    // Counter reload lands two edges after the TCFG write
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_wr_q <= 1'b0;
            reload    <= 1'b0;
        end else begin
            tcfg_wr_q <= tcfg_we;
            reload    <= tcfg_wr_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval     <= '0;
            time_out <= 1'b0;
        end else if (reload) begin
            tval     <= reload_val;
            time_out <= 1'b0;
        end else if (tcfg_en && tval != '0) begin
            tval     <= tval - 32'd1;
            time_out <= (tval == 32'd1);
        end else begin
            // Parked at zero unless periodic
            if (tcfg_en && tcfg_periodic) begin
                tval <= reload_val;
            end
            time_out <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ti <= 1'b0;
        end else if (ticlr_we) begin
            ti <= 1'b0;
        end else if (time_out) begin
            ti <= 1'b1;
        end
    end

endmodule

/* source/csr_top.sv */
module csr_top (
    input  logic               clk,
    input  logic               aresetn,
    input  csr_pkg::csr_addr_t addr,
    input  logic               wen,
    input  csr_pkg::csr_data_t wdata,
    input  logic               exception,
    input  logic               ertn,
    input  csr_pkg::ecode_t    ecode_in,
    input  csr_pkg::esubcode_t esubcode_in,
    input  csr_pkg::csr_data_t era_in,
    input  csr_pkg::hw_int_t   hw_int,
    output csr_pkg::csr_data_t rdata,
    output csr_pkg::csr_data_t crmd,
    output csr_pkg::csr_data_t era_out,
    output csr_pkg::csr_data_t eentry,
    output logic               cpu_interrupt
);

    csr_pkg::csr_data_t prmd;
    csr_pkg::csr_data_t save0;
    csr_pkg::csr_data_t save1;
    csr_pkg::csr_data_t save2;
    csr_pkg::csr_data_t save3;
    csr_pkg::int_vec_t  ecfg_lie;
    logic [1:0]         estat_soft;
    csr_pkg::ecode_t    estat_ecode;
    csr_pkg::esubcode_t estat_esubcode;
    csr_pkg::csr_data_t tid;
    csr_pkg::csr_data_t tcfg;
    csr_pkg::csr_data_t tval;
    logic               ti;

    csr_trap_regs u_trap_regs (
        .clk            (clk),
        .aresetn        (aresetn),
        .addr           (addr),
        .wen            (wen),
        .wdata          (wdata),
        .exception      (exception),
        .ertn           (ertn),
        .ecode_in       (ecode_in),
        .esubcode_in    (esubcode_in),
        .era_in         (era_in),
        .crmd           (crmd),
        .prmd           (prmd),
        .era            (era_out),
        .eentry         (eentry),
        .save0          (save0),
        .save1          (save1),
        .save2          (save2),
        .save3          (save3),
        .ecfg_lie       (ecfg_lie),
        .estat_soft     (estat_soft),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode)
    );

    csr_timer u_timer (
        .clk     (clk),
        .aresetn (aresetn),
        .addr    (addr),
        .wen     (wen),
        .wdata   (wdata),
        .tid     (tid),
        .tcfg    (tcfg),
        .tval    (tval),
        .ti      (ti)
    );

    csr_read_mux u_read_mux (
        .addr           (addr),
        .crmd           (crmd),
        .prmd           (prmd),
        .era            (era_out),
        .eentry         (eentry),
        .save0          (save0),
        .save1          (save1),
        .save2          (save2),
        .save3          (save3),
        .tid            (tid),
        .tcfg           (tcfg),
        .tval           (tval),
        .ecfg_lie       (ecfg_lie),
        .estat_soft     (estat_soft),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .ti             (ti),
        .hw_int         (hw_int),
        .rdata          (rdata),
        .cpu_interrupt  (cpu_interrupt)
    );

endmodule

/* source/csr_trap_regs.sv */
module csr_trap_regs (
    input  logic                 clk,
    input  logic                 aresetn,
    input  csr_pkg::csr_addr_t   addr,
    input  logic                 wen,
    input  csr_pkg::csr_data_t   wdata,
    input  logic                 exception,
    input  logic                 ertn,
    input  csr_pkg::ecode_t      ecode_in,
    input  csr_pkg::esubcode_t   esubcode_in,
    input  csr_pkg::csr_data_t   era_in,
    output csr_pkg::csr_data_t   crmd,
    output csr_pkg::csr_data_t   prmd,
    output csr_pkg::csr_data_t   era,
    output csr_pkg::csr_data_t   eentry,
    output csr_pkg::csr_data_t   save0,
    output csr_pkg::csr_data_t   save1,
    output csr_pkg::csr_data_t   save2,
    output csr_pkg::csr_data_t   save3,
    output csr_pkg::int_vec_t    ecfg_lie,
    output logic [1:0]           estat_soft,
    output csr_pkg::ecode_t      estat_ecode,
    output csr_pkg::esubcode_t   estat_esubcode
);

    csr_pkg::plv_t crmd_plv;
    logic          crmd_ie;
    logic          crmd_da;
    logic          crmd_pg;
    logic [1:0]    crmd_datf;
    logic [1:0]    crmd_datm;
    csr_pkg::plv_t prmd_pplv;
    logic          prmd_pie;
    logic [csr_pkg::DATA_W-1:csr_pkg::EENTRY_VA_LO] eentry_va;

    logic trap_take;
    logic csr_we;

    // ertn beats exception, both beat a software write
    assign trap_take = exception && !ertn;
    assign csr_we    = wen && !ertn && !exception;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (trap_take) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (csr_we && addr == csr_pkg::ADDR_CRMD) begin
            crmd_plv  <= wdata[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO];
            crmd_ie   <= wdata[csr_pkg::CRMD_IE];
            crmd_datf <= wdata[csr_pkg::CRMD_DATF_HI:csr_pkg::CRMD_DATF_LO];
            crmd_datm <= wdata[csr_pkg::CRMD_DATM_HI:csr_pkg::CRMD_DATM_LO];
            // Only a legal PG/DA pair is accepted
            if (wdata[csr_pkg::CRMD_PG] != wdata[csr_pkg::CRMD_DA]) begin
                crmd_pg <= wdata[csr_pkg::CRMD_PG];
                crmd_da <= wdata[csr_pkg::CRMD_DA];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_pplv      <= '0;
            prmd_pie       <= 1'b0;
            ecfg_lie       <= '0;
            estat_soft     <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            eentry_va      <= '0;
            save0          <= '0;
            save1          <= '0;
            save2          <= '0;
            save3          <= '0;
        end else if (trap_take) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            era            <= era_in;
            estat_ecode    <= ecode_in;
            estat_esubcode <= esubcode_in;
        end else if (csr_we) begin
            case (addr)
                csr_pkg::ADDR_PRMD: begin
                    prmd_pplv <= wdata[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO];
                    prmd_pie  <= wdata[csr_pkg::PRMD_PIE];
                end
                csr_pkg::ADDR_ECFG:   ecfg_lie <= wdata[csr_pkg::INT_VEC_W-1:0];
                // Only the software interrupt bits are writable
                csr_pkg::ADDR_ESTAT:  estat_soft <= wdata[csr_pkg::ESTAT_SOFT_HI:csr_pkg::ESTAT_SOFT_LO];
                csr_pkg::ADDR_ERA:    era <= wdata;
                csr_pkg::ADDR_EENTRY: eentry_va <= wdata[csr_pkg::DATA_W-1:csr_pkg::EENTRY_VA_LO];
                csr_pkg::ADDR_SAVE0:  save0 <= wdata;
                csr_pkg::ADDR_SAVE1:  save1 <= wdata;
                csr_pkg::ADDR_SAVE2:  save2 <= wdata;
                csr_pkg::ADDR_SAVE3:  save3 <= wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        crmd = '0;
        crmd[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO]   = crmd_plv;
        crmd[csr_pkg::CRMD_IE]                            = crmd_ie;
        crmd[csr_pkg::CRMD_DA]                            = crmd_da;
        crmd[csr_pkg::CRMD_PG]                            = crmd_pg;
        crmd[csr_pkg::CRMD_DATF_HI:csr_pkg::CRMD_DATF_LO] = crmd_datf;
        crmd[csr_pkg::CRMD_DATM_HI:csr_pkg::CRMD_DATM_LO] = crmd_datm;
    end

    always_comb begin
        prmd = '0;
        prmd[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO] = prmd_pplv;
        prmd[csr_pkg::PRMD_PIE]                           = prmd_pie;
    end

    assign eentry = {eentry_va, {csr_pkg::EENTRY_VA_LO{1'b0}}};

endmodule

/* verilog.f */
source/csr_pkg.sv
source/csr_trap_regs.sv
source/csr_timer.sv
source/csr_read_mux.sv
source/csr_top.sv
bench/tb_csr.sv
